// File: source/ccl_pkg.sv
package ccl_pkg;

    parameter int DEFAULT_LABEL_BITS = 7;
    parameter int DEFAULT_MAX_WIDTH  = 64;

    // Widest label the datapath carries
    parameter int LABEL_BITS = DEFAULT_LABEL_BITS;

    typedef logic [15:0]           coord_t;
    typedef logic [LABEL_BITS-1:0] label_t;
    typedef logic [15:0]           count_t;

    // Pixel count and bounding box of one label
    typedef struct packed {
        count_t count;
        coord_t min_x;
        coord_t min_y;
        coord_t max_x;
        coord_t max_y;
    } blob_stats_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        label_t label;
        logic   fresh;
    } labeled_pixel_t;

    typedef struct packed {
        label_t      label;
        blob_stats_t stats;
    } ranked_blob_t;

    // Largest blob first
    typedef struct packed {
        ranked_blob_t first;
        ranked_blob_t second;
        ranked_blob_t third;
    } blob_report_t;

endpackage

// File: source/raster_counter.sv
`timescale 1ns/1ns

module raster_counter (
    input  logic            clock,
    input  logic            reset_n,
    input  ccl_pkg::coord_t width,
    input  ccl_pkg::coord_t height,
    input  logic            pixel_valid,
    output ccl_pkg::coord_t x,
    output ccl_pkg::coord_t y,
    output logic            last
);

    import ccl_pkg::*;

    coord_t img_width;
    coord_t img_height;
    logic   last_col;
    logic   last_row;

    // Position of the pixel on the input this cycle
    assign last_col = (x == img_width - coord_t'(1));
    assign last_row = (y == img_height - coord_t'(1));
    assign last     = last_col && last_row;

    always_ff @(posedge clock) begin
        if (reset_n) begin
            img_width  <= width;
            img_height <= height;
            x          <= '0;
            y          <= '0;
        end else if (pixel_valid && !last) begin
            if (last_col) begin
                x <= '0;
                y <= y + coord_t'(1);
            end else begin
                x <= x + coord_t'(1);
            end
        end
    end

endmodule

// File: source/line_buffer.sv
`timescale 1ns/1ns

module line_buffer #(
    parameter int max_width = ccl_pkg::DEFAULT_MAX_WIDTH
) (
    input  logic            clock,
    input  logic            reset_n,
    input  logic            write,
    input  ccl_pkg::coord_t x,
    input  ccl_pkg::coord_t width,
    input  ccl_pkg::label_t label_in,
    output ccl_pkg::label_t west,
    output ccl_pkg::label_t north_west,
    output ccl_pkg::label_t north,
    output ccl_pkg::label_t north_east
);

    import ccl_pkg::*;

    localparam int addr_bits = (max_width > 1) ? $clog2(max_width) : 1;

    label_t               row [max_width];
    label_t               west_q;
    label_t               north_west_q;
    coord_t               row_width;
    coord_t               x_next;
    logic                 row_valid;
    logic                 at_left;
    logic                 at_right;
    logic [addr_bits-1:0] addr;

    assign x_next   = x + coord_t'(1);
    assign at_left  = (x == '0);
    assign at_right = (x_next >= row_width);
    assign addr     = x[addr_bits-1:0];

    // Row above is all background until the first row is complete
    assign west       = at_left ? '0 : west_q;
    assign north_west = (row_valid && !at_left) ? north_west_q : '0;
    assign north      = row_valid ? row[addr] : '0;
    assign north_east = (row_valid && !at_right) ? row[addr + 1'b1] : '0;

    always_ff @(posedge clock) begin
        if (write) begin
            row[addr]    <= label_in;
            west_q       <= label_in;
            // Previous row's label at x, kept before its slot is overwritten
            north_west_q <= row[addr];
        end
    end

    always_ff @(posedge clock) begin
        if (reset_n) begin
            row_width <= width;
            row_valid <= 1'b0;
        end else if (write && at_right) begin
            row_valid <= 1'b1;
        end
    end

    x_in_row: assert property (@(posedge clock) disable iff (reset_n)
        write |-> (x < coord_t'(max_width)));

endmodule

// File: source/component_labeler.sv
`timescale 1ns/1ns

module component_labeler #(
    parameter int label_bits = ccl_pkg::DEFAULT_LABEL_BITS,
    parameter int max_width  = ccl_pkg::DEFAULT_MAX_WIDTH
) (
    input  logic                    clock,
    input  logic                    reset_n,
    input  ccl_pkg::coord_t         width,
    input  ccl_pkg::coord_t         height,
    input  logic                    in_valid,
    input  logic                    in_pixel,
    output logic                    out_valid,
    output ccl_pkg::label_t         out_label,
    output ccl_pkg::labeled_pixel_t pixel_out,
    output logic                    frame_end,
    output ccl_pkg::label_t         labels_used
);

    import ccl_pkg::*;

    localparam label_t max_label = label_t'((1 << label_bits) - 1);

    coord_t x;
    coord_t y;
    logic   last;
    logic   accept;
    logic   frame_done;
    logic   fresh;
    label_t west;
    label_t north_west;
    label_t north;
    label_t north_east;
    label_t label;
    label_t next_label;

    // Pixels after the last one wait for the next reset
    assign accept = in_valid && !frame_done;

    raster_counter raster_counter_inst (
        .clock       (clock),
        .reset_n     (reset_n),
        .width       (width),
        .height      (height),
        .pixel_valid (accept),
        .x           (x),
        .y           (y),
        .last        (last)
    );

    line_buffer #(
        .max_width (max_width)
    ) line_buffer_inst (
        .clock      (clock),
        .reset_n    (reset_n),
        .write      (accept),
        .x          (x),
        .width      (width),
        .label_in   (label),
        .west       (west),
        .north_west (north_west),
        .north      (north),
        .north_east (north_east)
    );

    // --------------------------------------------------
    // Neighbour precedence W, NW, N, NE
    always_comb begin
        fresh = 1'b0;
        if (!in_pixel) begin
            label = '0;
        end else if (west != '0) begin
            label = west;
        end else if (north_west != '0) begin
            label = north_west;
        end else if (north != '0) begin
            label = north;
        end else if (north_east != '0) begin
            label = north_east;
        end else begin
            label = next_label;
            fresh = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset_n) begin
            out_valid  <= 1'b0;
            frame_end  <= 1'b0;
            frame_done <= 1'b0;
            next_label <= label_t'(1);
        end else begin
            out_valid <= accept;
            frame_end <= accept && last;
            if (accept && last) begin
                frame_done <= 1'b1;
            end
            if (accept && fresh) begin
                next_label <= next_label + label_t'(1);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            pixel_out <= '{x: x, y: y, label: label, fresh: fresh};
        end
    end

    assign out_label   = pixel_out.label;
    assign labels_used = next_label - label_t'(1);

    label_no_wrap: assert property (@(posedge clock) disable iff (reset_n)
        (accept && fresh) |-> ((next_label != '0) && (next_label <= max_label)));

endmodule

// File: source/blob_statistics.sv
`timescale 1ns/1ns

module blob_statistics #(
    parameter int label_bits = ccl_pkg::DEFAULT_LABEL_BITS
) (
    input  logic                    clock,
    input  logic                    reset_n,
    input  logic                    pixel_valid,
    input  ccl_pkg::labeled_pixel_t pixel_in,
    input  logic                    scan_req,
    input  ccl_pkg::label_t         scan_addr,
    output ccl_pkg::blob_stats_t    scan_data
);

    import ccl_pkg::*;

    blob_stats_t    stats_mem [1 << label_bits];
    blob_stats_t    stored;
    blob_stats_t    merged;
    labeled_pixel_t wr_pixel;
    logic           wr_en;
    logic           set_pixel;
    logic           forward;

    // Background pixels leave the table alone
    assign set_pixel = pixel_valid && (pixel_in.label != '0);

    // Same label twice in a row, take the entry being written
    assign forward = wr_en && (wr_pixel.label == pixel_in.label);

    // --------------------------------------------------
    // Read stage and table write
    always_ff @(posedge clock) begin
        if (set_pixel) begin
            stored   <= forward ? merged : stats_mem[pixel_in.label[label_bits-1:0]];
            wr_pixel <= pixel_in;
        end
        if (wr_en) begin
            stats_mem[wr_pixel.label[label_bits-1:0]] <= merged;
        end
        if (scan_req) begin
            scan_data <= stats_mem[scan_addr[label_bits-1:0]];
        end
    end

    always_ff @(posedge clock) begin
        if (reset_n) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= set_pixel;
        end
    end

    // --------------------------------------------------
    // Merge the pixel into its entry
    always_comb begin
        if (wr_pixel.fresh) begin
            // New label starts from an empty entry
            merged.count = count_t'(1);
            merged.min_x = wr_pixel.x;
            merged.min_y = wr_pixel.y;
            merged.max_x = wr_pixel.x;
            merged.max_y = wr_pixel.y;
        end else begin
            merged.count = stored.count + count_t'(1);
            merged.min_x = (wr_pixel.x < stored.min_x) ? wr_pixel.x : stored.min_x;
            merged.min_y = (wr_pixel.y < stored.min_y) ? wr_pixel.y : stored.min_y;
            merged.max_x = (wr_pixel.x > stored.max_x) ? wr_pixel.x : stored.max_x;
            merged.max_y = (wr_pixel.y > stored.max_y) ? wr_pixel.y : stored.max_y;
        end
    end

    // Every issued label must reach the write stage as a real entry
    fresh_not_background: assert property (@(posedge clock) disable iff (reset_n)
        (pixel_valid && pixel_in.fresh) |=> (wr_en && (wr_pixel.label != '0)));

endmodule

// File: source/largest_blobs.sv
`timescale 1ns/1ns

module largest_blobs (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  frame_end,
    input  ccl_pkg::label_t       labels_used,
    output logic                  scan_req,
    output ccl_pkg::label_t       scan_addr,
    input  ccl_pkg::blob_stats_t  scan_data,
    output ccl_pkg::blob_report_t report,
    output logic                  done
);

    import ccl_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        SETTLE,
        READ,
        RANK,
        FINISH
    } state_t;

    state_t       state;
    logic         settle_cnt;
    label_t       addr;
    ranked_blob_t entry;

    assign scan_req  = (state == READ);
    assign scan_addr = addr;
    assign done      = (state == FINISH);
    assign entry     = '{label: addr, stats: scan_data};

    // --------------------------------------------------
    // Scan FSM, one read and one insert per label
    always_ff @(posedge clock) begin
        if (reset_n) begin
            state      <= IDLE;
            settle_cnt <= 1'b0;
            addr       <= label_t'(1);
            report     <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (frame_end) begin
                        state <= SETTLE;
                    end
                end
                // Last table write lands during this wait
                SETTLE: begin
                    settle_cnt <= 1'b1;
                    if (settle_cnt) begin
                        state <= (labels_used == '0) ? FINISH : READ;
                    end
                end
                READ: begin
                    state <= RANK;
                end
                RANK: begin
                    // Strictly greater, so lower labels keep ties
                    if (entry.stats.count > report.first.stats.count) begin
                        report.third  <= report.second;
                        report.second <= report.first;
                        report.first  <= entry;
                    end else if (entry.stats.count > report.second.stats.count) begin
                        report.third  <= report.second;
                        report.second <= entry;
                    end else if (entry.stats.count > report.third.stats.count) begin
                        report.third <= entry;
                    end
                    if (addr == labels_used) begin
                        state <= FINISH;
                    end else begin
                        addr  <= addr + label_t'(1);
                        state <= READ;
                    end
                end
                FINISH: begin
                    state <= FINISH;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    slots_descending: assert property (@(posedge clock) disable iff (reset_n)
        (report.first.stats.count >= report.second.stats.count) &&
        (report.second.stats.count >= report.third.stats.count));

endmodule

// File: source/blob_analyzer.sv
`timescale 1ns/1ns

module blob_analyzer #(
    parameter int label_bits = ccl_pkg::DEFAULT_LABEL_BITS,
    parameter int max_width  = ccl_pkg::DEFAULT_MAX_WIDTH
) (
    input  logic                  clock,
    input  logic                  reset_n,
    input  ccl_pkg::coord_t       width,
    input  ccl_pkg::coord_t       height,
    input  logic                  in_valid,
    input  logic                  in_pixel,
    output logic                  out_valid,
    output ccl_pkg::label_t       out_label,
    output ccl_pkg::blob_report_t report,
    output logic                  done
);

    import ccl_pkg::*;

    labeled_pixel_t pixel;
    logic           frame_end;
    label_t         labels_used;
    logic           scan_req;
    label_t         scan_addr;
    blob_stats_t    scan_data;

    // --------------------------------------------------
    // Labelling, statistics table, ranking scan
    component_labeler #(
        .label_bits (label_bits),
        .max_width  (max_width)
    ) component_labeler_inst (
        .clock       (clock),
        .reset_n     (reset_n),
        .width       (width),
        .height      (height),
        .in_valid    (in_valid),
        .in_pixel    (in_pixel),
        .out_valid   (out_valid),
        .out_label   (out_label),
        .pixel_out   (pixel),
        .frame_end   (frame_end),
        .labels_used (labels_used)
    );

    blob_statistics #(
        .label_bits (label_bits)
    ) blob_statistics_inst (
        .clock       (clock),
        .reset_n     (reset_n),
        .pixel_valid (out_valid),
        .pixel_in    (pixel),
        .scan_req    (scan_req),
        .scan_addr   (scan_addr),
        .scan_data   (scan_data)
    );

    largest_blobs largest_blobs_inst (
        .clock       (clock),
        .reset_n     (reset_n),
        .frame_end   (frame_end),
        .labels_used (labels_used),
        .scan_req    (scan_req),
        .scan_addr   (scan_addr),
        .scan_data   (scan_data),
        .report      (report),
        .done        (done)
    );

endmodule

// File: dv/blob_model.svh
`ifndef BLOB_MODEL_SVH
`define BLOB_MODEL_SVH

localparam int IMG_W = 16;
localparam int IMG_H = 12;

bit          image      [IMG_H][IMG_W];
label_t      label_map  [IMG_H][IMG_W];
blob_stats_t blob_table [1 << LABEL_BITS];

// Raster-order labelling, returns the number of labels issued
function automatic int label_image(int w, int h);
    int     issued;
    int     x;
    int     y;
    label_t west;
    label_t north_west;
    label_t north;
    label_t north_east;
    label_t lbl;
    coord_t cx;
    coord_t cy;
    issued = 0;
    for (y = 0; y < h; y++) begin
        for (x = 0; x < w; x++) begin
            cx         = coord_t'(x);
            cy         = coord_t'(y);
            west       = (x > 0) ? label_map[y][x-1] : '0;
            north_west = (y > 0 && x > 0) ? label_map[y-1][x-1] : '0;
            north      = (y > 0) ? label_map[y-1][x] : '0;
            north_east = (y > 0 && x < w - 1) ? label_map[y-1][x+1] : '0;
            if (!image[y][x]) begin
                lbl = '0;
            end else if (west != '0) begin
                lbl = west;
            end else if (north_west != '0) begin
                lbl = north_west;
            end else if (north != '0) begin
                lbl = north;
            end else if (north_east != '0) begin
                lbl = north_east;
            end else begin
                issued++;
                lbl = label_t'(issued);
                blob_table[issued] = '{count: '0, min_x: cx, min_y: cy, max_x: cx, max_y: cy};
            end
            label_map[y][x] = lbl;
            if (lbl != '0) begin
                blob_table[lbl].count = blob_table[lbl].count + count_t'(1);
                if (cx < blob_table[lbl].min_x) blob_table[lbl].min_x = cx;
                if (cy < blob_table[lbl].min_y) blob_table[lbl].min_y = cy;
                if (cx > blob_table[lbl].max_x) blob_table[lbl].max_x = cx;
                if (cy > blob_table[lbl].max_y) blob_table[lbl].max_y = cy;
            end
        end
    end
    return issued;
endfunction

// Three largest by count, lower label first on equal counts
function automatic blob_report_t rank_blobs(int issued);
    ranked_blob_t slots [3];
    bit           taken [1 << LABEL_BITS];
    int           best;
    int           s;
    int           l;
    blob_report_t result;
    for (l = 0; l < (1 << LABEL_BITS); l++) begin
        taken[l] = 1'b0;
    end
    for (s = 0; s < 3; s++) begin
        slots[s] = '0;
        best     = 0;
        for (l = 1; l <= issued; l++) begin
            if (!taken[l] && (best == 0 || blob_table[l].count > blob_table[best].count)) begin
                best = l;
            end
        end
        if (best != 0) begin
            taken[best] = 1'b1;
            slots[s]    = '{label: label_t'(best), stats: blob_table[best]};
        end
    end
    result.first  = slots[0];
    result.second = slots[1];
    result.third  = slots[2];
    return result;
endfunction

`endif

// File: dv/blob_analyzer_tb.sv
`timescale 1ns/1ns

module blob_analyzer_tb;

    import ccl_pkg::*;

    `include "blob_model.svh"

    localparam int CLOCK_PERIOD    = 20;
    localparam int RANDOM_FRAMES   = 6;
    localparam int FRAMES          = 2 + 2 * RANDOM_FRAMES;
    localparam int WATCHDOG_CYCLES = FRAMES * (IMG_W * IMG_H * 4 + 64) + 1000;

    logic         clock = 1'b0;
    logic         reset_n;
    coord_t       width;
    coord_t       height;
    logic         in_valid;
    logic         in_pixel;
    logic         out_valid;
    label_t       out_label;
    blob_report_t report;
    logic         done;

    logic         pixel_expected;
    logic         pending = 1'b0;
    label_t       expect_q [$];
    blob_report_t expect_report;
    int unsigned  seed_value;

    blob_analyzer #(
        .label_bits (DEFAULT_LABEL_BITS),
        .max_width  (DEFAULT_MAX_WIDTH)
    ) blob_analyzer_inst (
        .clock     (clock),
        .reset_n   (reset_n),
        .width     (width),
        .height    (height),
        .in_valid  (in_valid),
        .in_pixel  (in_pixel),
        .out_valid (out_valid),
        .out_label (out_label),
        .report    (report),
        .done      (done)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    task automatic stop_on_error(string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("Errors found");
        $fatal(1, "Simulation stopped on first error");
    endtask

    // --------------------------------------------------
    // Output comparison, one cycle behind each accepted pixel
    always @(posedge clock) begin : compare_outputs
        label_t expected;
        if (reset_n) begin
            pending = 1'b0;
        end else begin
            assert (out_valid === pending)
                else stop_on_error($sformatf("out_valid %b, expected %b", out_valid, pending));
            if (out_valid) begin
                assert (expect_q.size() > 0)
                    else stop_on_error("labelled pixel with no pixel driven");
                expected = expect_q.pop_front();
                assert (out_label === expected)
                    else stop_on_error($sformatf("out_label %0d, expected %0d",
                                                 out_label, expected));
            end
            pending = in_valid && pixel_expected;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("Timeout, done never arrived within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $fatal(1, "Watchdog expired");
    end

    function automatic void clear_image();
        int x;
        int y;
        for (y = 0; y < IMG_H; y++) begin
            for (x = 0; x < IMG_W; x++) begin
                image[y][x] = 1'b0;
            end
        end
    endfunction

    function automatic void random_image(int w, int h, int percent);
        int x;
        int y;
        clear_image();
        for (y = 0; y < h; y++) begin
            for (x = 0; x < w; x++) begin
                image[y][x] = ($urandom_range(99) < percent);
            end
        end
    endfunction

    task automatic apply_reset(int w, int h);
        @(posedge clock);
        reset_n        <= 1'b1;
        width          <= coord_t'(w);
        height         <= coord_t'(h);
        in_valid       <= 1'b0;
        pixel_expected <= 1'b0;
        repeat (3) @(posedge clock);
        reset_n <= 1'b0;
        @(posedge clock);
        assert (!done && !out_valid && report == '0)
            else stop_on_error($sformatf("after reset done %b out_valid %b report %h",
                                         done, out_valid, report));
    endtask

    task automatic drive_frame(int w, int h, bit gaps);
        int x;
        int y;
        int idle;
        for (y = 0; y < h; y++) begin
            for (x = 0; x < w; x++) begin
                if (gaps && $urandom_range(3) == 0) begin
                    idle = 1 + $urandom_range(1);
                    repeat (idle) begin
                        @(posedge clock);
                        assert (!done) else stop_on_error("done high before frame end");
                        in_valid <= 1'b0;
                        in_pixel <= 1'($urandom);
                    end
                end
                @(posedge clock);
                assert (!done) else stop_on_error("done high before frame end");
                in_valid       <= 1'b1;
                in_pixel       <= image[y][x];
                pixel_expected <= 1'b1;
                expect_q.push_back(label_map[y][x]);
            end
        end
        @(posedge clock);
        in_valid       <= 1'b0;
        pixel_expected <= 1'b0;
    endtask

    // Extra pixels once the frame is over must be ignored
    task automatic drive_after_done();
        repeat (8) begin
            @(posedge clock);
            in_valid <= 1'b1;
            in_pixel <= 1'($urandom);
        end
        @(posedge clock);
        in_valid <= 1'b0;
        repeat (2) @(posedge clock);
        assert (done && report == expect_report)
            else stop_on_error($sformatf("after extra pixels done %b report %h, expected %h",
                                         done, report, expect_report));
    endtask

    task automatic run_frame(int w, int h, bit gaps);
        int issued;
        issued        = label_image(w, h);
        expect_report = rank_blobs(issued);
        apply_reset(w, h);
        drive_frame(w, h, gaps);
        while (!done) @(posedge clock);
        assert (expect_q.size() == 0)
            else stop_on_error($sformatf("%0d labelled pixels missing", expect_q.size()));
        assert (report == expect_report)
            else stop_on_error($sformatf("report %h, expected %h", report, expect_report));
        drive_after_done();
    endtask

    // --------------------------------------------------
    // Test sequence
    initial begin : main
        int i;
        int w;
        int h;
        reset_n        = 1'b1;
        width          = '0;
        height         = '0;
        in_valid       = 1'b0;
        in_pixel       = 1'b0;
        pixel_expected = 1'b0;
        seed_value     = $urandom(32'h471854db);

        // All background
        clear_image();
        run_frame(IMG_W, IMG_H, 1'b1);
        assert (report == '0) else stop_on_error($sformatf("empty frame report %h", report));

        // Two isolated 2x2 blobs of equal size
        clear_image();
        image[1][1] = 1'b1;
        image[1][2] = 1'b1;
        image[2][1] = 1'b1;
        image[2][2] = 1'b1;
        image[3][6] = 1'b1;
        image[3][7] = 1'b1;
        image[4][6] = 1'b1;
        image[4][7] = 1'b1;
        run_frame(10, 6, 1'b0);
        assert (report.first.label == label_t'(1) && report.second.label == label_t'(2))
            else stop_on_error($sformatf("tie order %0d then %0d",
                                         report.first.label, report.second.label));

        // Same image without and with idle gaps
        for (i = 0; i < RANDOM_FRAMES; i++) begin
            w = (i == 0) ? IMG_W : 1 + $urandom_range(IMG_W - 1);
            h = (i == 0) ? IMG_H : 1 + $urandom_range(IMG_H - 1);
            random_image(w, h, 30 + $urandom_range(30));
            run_frame(w, h, 1'b0);
            run_frame(w, h, 1'b1);
        end

        $display("No errors");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+dv
source/ccl_pkg.sv
source/raster_counter.sv
source/line_buffer.sv
source/component_labeler.sv
source/blob_statistics.sv
source/largest_blobs.sv
source/blob_analyzer.sv
dv/blob_analyzer_tb.sv
